// File: verilog/stepper_pkg.sv
/*
 * stepper controller package
 * memory map, register offsets, SPI frame constants,
 * motion FSM state codes and the motion command word
 */
`default_nettype none

package stepper_pkg;

  // scratch RAM window
  localparam logic [31:0] RAM_BASE  = 32'h0000_1000;
  localparam int          RAM_WORDS = 1024;

  // register window
  localparam logic [31:0] IO_BASE = 32'h1000_0000;
  localparam logic [31:0] IO_SPAN = 32'h0000_0020;

  // register byte offsets inside the io window
  localparam logic [4:0] REG_CTRL        = 5'h00;
  localparam logic [4:0] REG_PERIOD      = 5'h04;
  localparam logic [4:0] REG_STATUS      = 5'h08;
  localparam logic [4:0] REG_SPI_ADDR    = 5'h0C;
  localparam logic [4:0] REG_SPI_DATA    = 5'h10;
  localparam logic [4:0] REG_SPI_RX_ADDR = 5'h14;
  localparam logic [4:0] REG_SPI_RX_DATA = 5'h18;
  localparam logic [4:0] REG_LED         = 5'h1C;

  // driver datagram, 8 bit address over 32 data bits
  localparam int SPI_FRAME_BITS = 40;
  // system clocks per sck half period
  localparam int SPI_CLK_DIV    = 4;

  // motion fsm state codes
  localparam logic [1:0] MS_IDLE      = 2'd0;
  localparam logic [1:0] MS_STEP_HIGH = 2'd1;
  localparam logic [1:0] MS_STEP_LOW  = 2'd2;

  typedef logic [SPI_FRAME_BITS-1:0] spi_frame_t;

  // motion command fields, msb first
  typedef struct packed {
    logic [15:0] steps;
    logic [12:0] reserved;
    logic        driver_en;
    logic        dir;
    logic        start;
  } cmd_fields_t;

  // bus side sees raw, motion side sees fields
  typedef union packed {
    logic [31:0] raw;
    cmd_fields_t f;
  } cmd_word_u;

endpackage

`default_nettype wire

// File: verilog/bus_decoder.sv
/*
 * bus address decoder
 * registers a one-cycle target select from the native bus request,
 * answers with mem_ready one edge later and muxes the read data
 */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder import stepper_pkg::*; (
  input  wire         clk_25mhz,
  input  wire         rst_n,
  input  wire         mem_valid,
  input  wire  [31:0] mem_addr,
  input  wire  [3:0]  mem_wstrb,
  input  wire  [31:0] ram_rdata,
  input  wire  [31:0] io_rdata,
  output logic        ram_sel,
  output logic        io_sel,
  output logic        mem_ready,
  output logic [31:0] mem_rdata
);

  logic ram_hit;
  logic io_hit;
  logic accept;
  logic busy;
  logic req_q;
  logic rd_ram_q;
  logic rd_io_q;

  // window compares
  assign ram_hit = (mem_addr >= RAM_BASE) && (mem_addr < RAM_BASE + 32'(RAM_WORDS * 4));
  assign io_hit  = (mem_addr >= IO_BASE) && (mem_addr < IO_BASE + IO_SPAN);
  // held request is taken only once
  assign accept  = mem_valid && !busy;

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      ram_sel   <= 1'b0;
      io_sel    <= 1'b0;
      req_q     <= 1'b0;
      busy      <= 1'b0;
      mem_ready <= 1'b0;
      rd_ram_q  <= 1'b0;
      rd_io_q   <= 1'b0;
    end else begin
      // select pulses, at most one target
      ram_sel   <= accept && ram_hit;
      io_sel    <= accept && io_hit && !ram_hit;
      req_q     <= accept;
      // ready follows the select by one edge, unmapped too
      mem_ready <= req_q;
      if (accept) begin
        busy     <= 1'b1;
        // remember the read source, writes return zero
        rd_ram_q <= ram_hit && (mem_wstrb == 4'b0000);
        rd_io_q  <= io_hit && !ram_hit && (mem_wstrb == 4'b0000);
      end else if (mem_ready) begin
        // master drops valid on this edge
        busy <= 1'b0;
      end
    end
  end

  assign mem_rdata = rd_ram_q ? ram_rdata :
                     rd_io_q  ? io_rdata  : 32'd0;

endmodule

`default_nettype wire

// File: verilog/scratch_ram.sv
/*
 * scratch RAM
 * 1024 words, byte write strobes, registered read on select
 */
`timescale 1ns/1ps
`default_nettype none

module scratch_ram import stepper_pkg::*; (
  input  wire         clk_25mhz,
  input  wire         ram_sel,
  input  wire  [31:0] mem_addr,
  input  wire  [31:0] mem_wdata,
  input  wire  [3:0]  mem_wstrb,
  output logic [31:0] ram_rdata
);

  logic [31:0] mem [RAM_WORDS];
  logic [9:0]  idx;

  // word index, base bit 12 drops out
  assign idx = mem_addr[11:2];

  always_ff @(posedge clk_25mhz) begin
    if (ram_sel) begin
      // strobed byte lanes only
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) begin
          mem[idx][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
      // old word on a write, decoder drops it anyway
      ram_rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: verilog/io_regs.sv
/*
 * memory-mapped register block
 * LED, motion command and period, status, SPI transmit and receive;
 * raises start pulses for the motion FSM and the SPI master
 */
`timescale 1ns/1ps
`default_nettype none

module io_regs import stepper_pkg::*; (
  input  wire               clk_25mhz,
  input  wire               rst_n,
  input  wire               io_sel,
  input  wire        [31:0] mem_addr,
  input  wire        [31:0] mem_wdata,
  input  wire        [3:0]  mem_wstrb,
  input  wire               busy,
  input  wire               done,
  input  wire signed [15:0] position,
  input  wire               spi_busy,
  input  wire spi_frame_t   rx_frame,
  output logic       [31:0] io_rdata,
  output cmd_word_u         cmd,
  output logic              cmd_start,
  output logic       [15:0] half_period,
  output logic              spi_start,
  output spi_frame_t        tx_frame,
  output logic       [7:0]  led
);

  logic      [4:0] offset;
  logic            wr;
  logic      [7:0] spi_addr;
  cmd_word_u       wcmd;

  assign offset   = mem_addr[4:0];
  assign wr       = io_sel && (mem_wstrb != 4'b0000);
  // incoming word seen as a command
  assign wcmd.raw = mem_wdata;

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      cmd.raw     <= 32'd0;
      half_period <= 16'd0;
      spi_addr    <= 8'd0;
      led         <= 8'd0;
      tx_frame    <= '0;
      cmd_start   <= 1'b0;
      spi_start   <= 1'b0;
    end else begin
      // pulses by default
      cmd_start <= 1'b0;
      spi_start <= 1'b0;
      if (wr) begin
        case (offset)
          REG_CTRL: begin
            cmd.raw   <= mem_wdata;
            cmd_start <= wcmd.f.start;
          end
          REG_PERIOD:   half_period <= mem_wdata[15:0];
          REG_SPI_ADDR: spi_addr    <= mem_wdata[7:0];
          REG_SPI_DATA: begin
            // address byte on top of the data word
            tx_frame  <= {spi_addr, mem_wdata};
            spi_start <= 1'b1;
          end
          REG_LED:      led         <= mem_wdata[7:0];
          default: ;
        endcase
      end
    end
  end

  // readback, registered with the access
  always_ff @(posedge clk_25mhz) begin
    if (io_sel) begin
      case (offset)
        REG_CTRL:        io_rdata <= cmd.raw;
        REG_PERIOD:      io_rdata <= {16'd0, half_period};
        REG_STATUS:      io_rdata <= {position, 13'd0, spi_busy, done, busy};
        REG_SPI_ADDR:    io_rdata <= {24'd0, spi_addr};
        REG_SPI_DATA:    io_rdata <= tx_frame[31:0];
        REG_SPI_RX_ADDR: io_rdata <= {24'd0, rx_frame[39:32]};
        REG_SPI_RX_DATA: io_rdata <= rx_frame[31:0];
        REG_LED:         io_rdata <= {24'd0, led};
        default:         io_rdata <= 32'd0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/motion_fsm.sv
/*
 * motion state machine
 * runs one step command as high and low phases paced by the
 * step timer, counts steps down and tracks the signed position
 */
`timescale 1ns/1ps
`default_nettype none

module motion_fsm import stepper_pkg::*; (
  input  wire                clk_25mhz,
  input  wire                rst_n,
  input  wire                cmd_start,
  input  wire  cmd_word_u    cmd,
  input  wire                tick,
  output logic               timer_load,
  output logic               step,
  output logic               busy,
  output logic               done,
  output logic signed [15:0] position
);

  logic [1:0]  state;
  logic [15:0] remaining;
  logic        go;

  // accepted start with work to do
  assign go = (state == MS_IDLE) && cmd_start && (cmd.f.steps != 16'd0);

  // timer restarts on the edge where step rises
  assign timer_load = go;

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      state     <= MS_IDLE;
      remaining <= 16'd0;
      step      <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      position  <= 16'sd0;
    end else begin
      case (state)
        MS_IDLE: begin
          if (cmd_start) begin
            if (go) begin
              remaining <= cmd.f.steps;
              step      <= 1'b1;
              busy      <= 1'b1;
              done      <= 1'b0;
              state     <= MS_STEP_HIGH;
            end else begin
              // zero steps, finished at once
              done <= 1'b1;
            end
          end
        end
        MS_STEP_HIGH: begin
          if (tick) begin
            step  <= 1'b0;
            state <= MS_STEP_LOW;
          end
        end
        MS_STEP_LOW: begin
          if (tick) begin
            // one full step completed
            remaining <= remaining - 16'd1;
            if (cmd.f.dir) begin
              position <= position + 16'sd1;
            end else begin
              position <= position - 16'sd1;
            end
            if (remaining == 16'd1) begin
              busy  <= 1'b0;
              done  <= 1'b1;
              state <= MS_IDLE;
            end else begin
              step  <= 1'b1;
              state <= MS_STEP_HIGH;
            end
          end
        end
        default: state <= MS_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/step_timer.sv
/*
 * step phase timer
 * counts system clocks up to the half period and pulses tick,
 * then starts the next phase on its own
 */
`timescale 1ns/1ps
`default_nettype none

module step_timer (
  input  wire        clk_25mhz,
  input  wire        rst_n,
  input  wire        timer_load,
  input  wire [15:0] half_period,
  output logic       tick
);

  logic [15:0] cnt;
  logic [15:0] hp_eff;
  logic        run;

  // zero period behaves as one
  assign hp_eff = (half_period == 16'd0) ? 16'd1 : half_period;

  // >= so a shrinking period mid phase still ends it
  assign tick = run && (cnt >= hp_eff);

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      cnt <= 16'd0;
      run <= 1'b0;
    end else if (timer_load) begin
      // first cycle of the phase counts as one
      cnt <= 16'd1;
      run <= 1'b1;
    end else if (tick) begin
      cnt <= 16'd1;
    end else if (run) begin
      cnt <= cnt + 16'd1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/spi_master.sv
/*
 * SPI master, mode 3
 * shifts one 40-bit driver frame out MSB first and samples the
 * returned bits into the same register
 */
`timescale 1ns/1ps
`default_nettype none

module spi_master import stepper_pkg::*; (
  input  wire         clk_25mhz,
  input  wire         rst_n,
  input  wire         spi_start,
  input  wire  spi_frame_t tx_frame,
  input  wire         spi_miso,
  output logic        spi_sck,
  output logic        spi_mosi,
  output logic        spi_cs_n,
  output logic        spi_busy,
  output spi_frame_t  rx_frame
);

  logic [$clog2(SPI_CLK_DIV)-1:0]      div_cnt;
  logic [$clog2(SPI_FRAME_BITS+1)-1:0] bit_cnt;
  logic                                half_end;

  // end of an sck half period
  assign half_end = (div_cnt == ($bits(div_cnt))'(SPI_CLK_DIV - 1));

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      spi_sck  <= 1'b1;
      spi_mosi <= 1'b0;
      spi_cs_n <= 1'b1;
      spi_busy <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      rx_frame <= '0;
    end else if (!spi_busy) begin
      if (spi_start) begin
        // load transmit frame, select the driver
        rx_frame <= tx_frame;
        spi_cs_n <= 1'b0;
        spi_busy <= 1'b1;
        div_cnt  <= '0;
        bit_cnt  <= '0;
      end
    end else if (half_end) begin
      div_cnt <= '0;
      if (spi_sck) begin
        if (bit_cnt == ($bits(bit_cnt))'(SPI_FRAME_BITS)) begin
          // last rise was one half period ago
          spi_cs_n <= 1'b1;
          spi_busy <= 1'b0;
          spi_mosi <= 1'b0;
        end else begin
          // falling sck, present next bit
          spi_sck  <= 1'b0;
          spi_mosi <= rx_frame[SPI_FRAME_BITS-1];
        end
      end else begin
        // rising sck, sample miso into the freed lsb
        spi_sck  <= 1'b1;
        rx_frame <= {rx_frame[SPI_FRAME_BITS-2:0], spi_miso};
        bit_cnt  <= bit_cnt + 1'b1;
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/stepper_top.sv
/*
 * stepper controller top
 * native memory bus slave with scratch RAM, register block,
 * step and direction generation and driver SPI
 */
`timescale 1ns/1ps
`default_nettype none

module stepper_top import stepper_pkg::*; (
  input  wire         clk_25mhz,
  input  wire         rst_n,
  input  wire         mem_valid,
  input  wire  [31:0] mem_addr,
  input  wire  [31:0] mem_wdata,
  input  wire  [3:0]  mem_wstrb,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  output logic        step,
  output logic        dir,
  output logic        drv_en,
  output logic [7:0]  led,
  output logic        spi_sck,
  output logic        spi_mosi,
  output logic        spi_cs_n,
  input  wire         spi_miso
);

  logic               ram_sel;
  logic               io_sel;
  logic [31:0]        ram_rdata;
  logic [31:0]        io_rdata;
  cmd_word_u          cmd;
  logic               cmd_start;
  logic [15:0]        half_period;
  logic               timer_load;
  logic               tick;
  logic               busy;
  logic               done;
  logic signed [15:0] position;
  logic               spi_start;
  logic               spi_busy;
  spi_frame_t         tx_frame;
  spi_frame_t         rx_frame;

  // pins straight from the command word
  assign dir    = cmd.f.dir;
  assign drv_en = cmd.f.driver_en;

  bus_decoder u_dec (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wstrb (mem_wstrb),
    .ram_rdata (ram_rdata),
    .io_rdata  (io_rdata),
    .ram_sel   (ram_sel),
    .io_sel    (io_sel),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  scratch_ram u_ram (
    .clk_25mhz (clk_25mhz),
    .ram_sel   (ram_sel),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .ram_rdata (ram_rdata)
  );

  io_regs u_regs (
    .clk_25mhz   (clk_25mhz),
    .rst_n       (rst_n),
    .io_sel      (io_sel),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .busy        (busy),
    .done        (done),
    .position    (position),
    .spi_busy    (spi_busy),
    .rx_frame    (rx_frame),
    .io_rdata    (io_rdata),
    .cmd         (cmd),
    .cmd_start   (cmd_start),
    .half_period (half_period),
    .spi_start   (spi_start),
    .tx_frame    (tx_frame),
    .led         (led)
  );

  motion_fsm u_fsm (
    .clk_25mhz  (clk_25mhz),
    .rst_n      (rst_n),
    .cmd_start  (cmd_start),
    .cmd        (cmd),
    .tick       (tick),
    .timer_load (timer_load),
    .step       (step),
    .busy       (busy),
    .done       (done),
    .position   (position)
  );

  step_timer u_timer (
    .clk_25mhz   (clk_25mhz),
    .rst_n       (rst_n),
    .timer_load  (timer_load),
    .half_period (half_period),
    .tick        (tick)
  );

  spi_master u_spi (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .spi_start (spi_start),
    .tx_frame  (tx_frame),
    .spi_miso  (spi_miso),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .spi_cs_n  (spi_cs_n),
    .spi_busy  (spi_busy),
    .rx_frame  (rx_frame)
  );

endmodule

`default_nettype wire

// File: verification/stepper_tb.sv
/*
 * stepper controller testbench
 * acts as the native bus master, loops SPI back and checks
 * reset state, RAM, LED, motion and driver SPI with directed tests
 */
`timescale 1ns/1ps
`default_nettype none

module stepper_tb import stepper_pkg::*; ();

  localparam int STEPS_A   = 5;
  localparam int PERIOD_A  = 3;
  localparam int STEPS_B   = 8;
  localparam int PERIOD_B  = 2;
  localparam int RAM_TRIES = 8;
  // every step phase, two SPI frames, then margin
  localparam int LIMIT = STEPS_A * 2 * PERIOD_A + STEPS_B * 2 * PERIOD_B
                         + 2 * SPI_FRAME_BITS * 2 * SPI_CLK_DIV + 2000;

  logic        clk_25mhz = 1'b0;
  logic        rst_n;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic        step;
  logic        dir;
  logic        drv_en;
  logic [7:0]  led;
  logic        spi_sck;
  logic        spi_mosi;
  logic        spi_cs_n;
  logic        spi_miso;

  int          error_count = 0;
  int          check_count = 0;
  int          test_count  = 0;
  int          test_fail   = 0;
  int          cycles      = 0;
  logic [15:0] lfsr_state  = 16'd36;
  logic [31:0] ram_model [RAM_WORDS];

  // monitor state
  int          rise_count = 0;
  int          high_cnt   = 0;
  int          min_high   = 0;
  int          max_high   = 0;
  logic        prev_step  = 1'b0;
  logic        prev_sck   = 1'b1;
  spi_frame_t  cap_frame  = '0;
  int          cap_bits   = 0;

  always #20 clk_25mhz = ~clk_25mhz;

  // port names match the top level
  stepper_top i_dut (.*);

  // loopback, x before reset reads as zero
  assign spi_miso = (spi_mosi === 1'b1);

  always @(posedge clk_25mhz) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // mid-cycle sampling of step and sck
  always @(negedge clk_25mhz) begin
    if (step) begin
      high_cnt = high_cnt + 1;
      if (!prev_step) begin
        rise_count = rise_count + 1;
      end
    end else if (prev_step) begin
      min_high = (high_cnt < min_high) ? high_cnt : min_high;
      max_high = (high_cnt > max_high) ? high_cnt : max_high;
      high_cnt = 0;
    end
    prev_step = step;
    // mosi taken on rising sck inside the frame
    if (spi_sck && !prev_sck && !spi_cs_n) begin
      cap_frame = {cap_frame[SPI_FRAME_BITS-2:0], spi_mosi};
      cap_bits  = cap_bits + 1;
    end
    prev_sck = spi_sck;
  end

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] galois_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = galois_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] io_addr(input logic [4:0] off);
    return IO_BASE + {27'd0, off};
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_frame(input string name, input spi_frame_t got,
                             input spi_frame_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // one request, held until mem_ready, dropped the edge after
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata  = 32'd0;
    @(posedge clk_25mhz);
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= wdata;
    mem_wstrb <= wstrb;
    do begin
      @(negedge clk_25mhz);
      waited++;
    end while (!mem_ready && waited < 16);
    if (mem_ready) begin
      rdata = mem_rdata;
    end else begin
      error_count++;
      $display("bus access to %h never got mem_ready", addr);
    end
    @(posedge clk_25mhz);
    mem_valid <= 1'b0;
    mem_wstrb <= 4'b0000;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    logic [31:0] unused;
    bus_access(addr, wdata, wstrb, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_access(addr, 32'd0, 4'b0000, rdata);
  endtask

  // polls STATUS, bounded by the cycle limit
  task automatic wait_status(input int bit_idx, input logic value,
                             output logic [31:0] st);
    do begin
      bus_read(io_addr(REG_STATUS), st);
    end while (st[bit_idx] !== value);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      test_fail++;
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic test_reset();
    int          errs;
    logic [31:0] rd;
    errs = error_count;
    @(negedge clk_25mhz);
    check_bit("step", step, 1'b0);
    check_bit("dir", dir, 1'b0);
    check_bit("drv_en", drv_en, 1'b0);
    check_bit("spi_cs_n", spi_cs_n, 1'b1);
    check_bit("spi_sck", spi_sck, 1'b1);
    check_bit("spi_mosi", spi_mosi, 1'b0);
    check_bit("mem_ready", mem_ready, 1'b0);
    check_word("led", {24'd0, led}, 32'd0);
    bus_read(io_addr(REG_STATUS), rd);
    check_word("status", rd, 32'd0);
    bus_read(io_addr(REG_LED), rd);
    check_word("led reg", rd, 32'd0);
    bus_read(io_addr(REG_SPI_RX_ADDR), rd);
    check_word("spi rx addr", rd, 32'd0);
    bus_read(io_addr(REG_SPI_RX_DATA), rd);
    check_word("spi rx data", rd, 32'd0);
    finish_test("reset", errs);
  endtask

  task automatic test_ram();
    int          errs;
    logic [9:0]  idx [RAM_TRIES];
    logic [31:0] wd;
    logic [31:0] rd;
    logic [3:0]  strb;
    errs = error_count;
    for (int i = 0; i < RAM_TRIES; i++) begin
      idx[i] = 10'(rand_bits(10));
      wd = rand_bits(32);
      ram_model[idx[i]] = wd;
      bus_write(RAM_BASE + {20'd0, idx[i], 2'b00}, wd, 4'b1111);
    end
    // partial writes merged byte by byte into the model
    for (int i = 0; i < RAM_TRIES; i++) begin
      wd   = rand_bits(32);
      strb = 4'(rand_bits(4));
      // an empty strobe would be a read
      if (strb == 4'b0000) begin
        strb = 4'b0001;
      end
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          ram_model[idx[i]][8*b +: 8] = wd[8*b +: 8];
        end
      end
      bus_write(RAM_BASE + {20'd0, idx[i], 2'b00}, wd, strb);
    end
    for (int i = 0; i < RAM_TRIES; i++) begin
      bus_read(RAM_BASE + {20'd0, idx[i], 2'b00}, rd);
      check_word("mem_rdata", rd, ram_model[idx[i]]);
    end
    // nothing mapped here
    bus_read(32'h2000_0000, rd);
    check_word("mem_rdata unmapped", rd, 32'd0);
    finish_test("ram", errs);
  endtask

  task automatic test_led();
    int          errs;
    logic [31:0] val;
    logic [31:0] rd;
    errs = error_count;
    val  = rand_bits(32);
    bus_write(io_addr(REG_LED), val, 4'b1111);
    @(negedge clk_25mhz);
    check_word("led", {24'd0, led}, {24'd0, val[7:0]});
    bus_read(io_addr(REG_LED), rd);
    check_word("led reg", rd, {24'd0, val[7:0]});
    finish_test("led", errs);
  endtask

  // one move with a second start thrown in while it runs
  task automatic run_move(input logic [15:0] steps, input logic dir_bit,
                          input logic [15:0] period, input logic [15:0] exp_pos);
    cmd_word_u   c;
    logic [31:0] st;
    c.raw         = 32'd0;
    c.f.steps     = steps;
    c.f.driver_en = 1'b1;
    c.f.dir       = dir_bit;
    c.f.start     = 1'b1;
    rise_count    = 0;
    min_high      = 32'h7fff_ffff;
    max_high      = 0;
    bus_write(io_addr(REG_PERIOD), {16'd0, period}, 4'b1111);
    bus_write(io_addr(REG_CTRL), c.raw, 4'b1111);
    @(negedge clk_25mhz);
    check_bit("dir", dir, dir_bit);
    check_bit("drv_en", drv_en, 1'b1);
    check_bit("step", step, 1'b1);
    bus_write(io_addr(REG_CTRL), c.raw, 4'b1111);
    wait_status(1, 1'b1, st);
    check_word("step rises", rise_count, {16'd0, steps});
    check_word("step min high", min_high, {16'd0, period});
    check_word("step max high", max_high, {16'd0, period});
    check_bit("status busy", st[0], 1'b0);
    check_word("position", {16'd0, st[31:16]}, {16'd0, exp_pos});
  endtask

  task automatic test_motion();
    int errs;
    errs = error_count;
    run_move(16'(STEPS_A), 1'b1, 16'(PERIOD_A), 16'(STEPS_A));
    // backwards past zero, two's complement
    run_move(16'(STEPS_B), 1'b0, 16'(PERIOD_B), 16'(STEPS_A - STEPS_B));
    finish_test("motion", errs);
  endtask

  task automatic test_spi();
    int          errs;
    logic [7:0]  a;
    logic [31:0] d;
    logic [31:0] st;
    logic [31:0] rd_a;
    logic [31:0] rd_d;
    spi_frame_t  exp;
    errs     = error_count;
    a        = 8'(rand_bits(8));
    d        = rand_bits(32);
    exp      = {a, d};
    cap_bits = 0;
    bus_write(io_addr(REG_SPI_ADDR), {24'd0, a}, 4'b1111);
    bus_write(io_addr(REG_SPI_DATA), d, 4'b1111);
    wait_status(2, 1'b0, st);
    check_word("spi bits", cap_bits, SPI_FRAME_BITS);
    check_frame("spi_mosi frame", cap_frame, exp);
    bus_read(io_addr(REG_SPI_RX_ADDR), rd_a);
    bus_read(io_addr(REG_SPI_RX_DATA), rd_d);
    check_frame("rx_frame", {rd_a[7:0], rd_d}, exp);
    @(negedge clk_25mhz);
    check_bit("spi_cs_n", spi_cs_n, 1'b1);
    check_bit("spi_sck", spi_sck, 1'b1);
    finish_test("spi", errs);
  endtask

  initial begin
    rst_n     <= 1'b0;
    mem_valid <= 1'b0;
    mem_addr  <= 32'd0;
    mem_wdata <= 32'd0;
    mem_wstrb <= 4'b0000;
    repeat (5) @(posedge clk_25mhz);
    rst_n <= 1'b1;
    test_reset();
    test_ram();
    test_led();
    test_motion();
    test_spi();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, test_fail, check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/stepper_pkg.sv
verilog/bus_decoder.sv
verilog/scratch_ram.sv
verilog/io_regs.sv
verilog/motion_fsm.sv
verilog/step_timer.sv
verilog/spi_master.sv
verilog/stepper_top.sv
verification/stepper_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the stepper testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module stepper_tb \
  -f tb.f -o stepper_sim > build.log 2>&1 \
  && ./obj_dir/stepper_sim > sim.log 2>&1 \
  || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Verification passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
